// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= cpuTb
RTL_TOP   ?= cpuCore
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(BUILD_DIR)

// File: cpuCore.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuCore import cpuPkg::*; (
    input  logic             clk,
    input  logic             reset,
    output logic [`XLEN-1:0] instAddr,
    output logic             instRead,
    input  logic [`XLEN-1:0] instData,
    input  logic             instValid,
    output dataReq_t         dataReq,
    input  logic [`XLEN-1:0] dataRdata,
    input  logic             dataValid,
    output wbTrace_t         trace
);
    logic                   fetchAccept;
    logic                   branchTaken;
    logic [`XLEN-1:0]       branchTarget;
    logic                   decodeHold;
    logic                   memBusy;
    logic [`REG_ADDR_W-1:0] readAddr1;
    logic [`REG_ADDR_W-1:0] readAddr2;
    logic [`XLEN-1:0]       readData1;
    logic [`XLEN-1:0]       readData2;
    decodedOp_t             decodedOut;
    execResult_t            execOut;
    fwdSource_t             execFwd;
    fwdSource_t             memFwd;
    fwdSource_t             wbFwd;
    logic                   rfWriteEn;
    logic [`REG_ADDR_W-1:0] rfWriteAddr;
    logic [`XLEN-1:0]       rfWriteData;

    programCounter pcUnit (
        .clk, .reset, .instValid, .branchTaken, .decodeHold, .memBusy,
        .branchTarget, .instAddr, .instRead, .fetchAccept
    );

    registerFile regFile (
        .clk, .reset, .readAddr1, .readAddr2, .readData1, .readData2,
        .writeEn(rfWriteEn), .writeAddr(rfWriteAddr), .writeData(rfWriteData)
    );

    decodeUnit decode (
        .clk, .reset, .fetchAccept, .instData, .instAddr, .memBusy,
        .execFwd, .memFwd, .wbFwd, .readAddr1, .readAddr2, .readData1, .readData2,
        .decodeHold, .branchTaken, .branchTarget, .decodedOut
    );

    executeUnit execute (
        .clk, .reset, .memBusy, .decodedIn(decodedOut), .execOut, .execFwd
    );

    memoryAccess memory (
        .clk, .reset, .execIn(execOut), .dataRdata, .dataValid, .dataReq, .memBusy,
        .memFwd, .wbFwd, .rfWriteEn, .rfWriteAddr, .rfWriteData, .trace
    );

endmodule

// File: cpuPkg.sv
`include "cpu_settings.svh"

package cpuPkg;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } rFields_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm16;
    } iFields_t;

    // Same word, read as R-type or I-type in decode
    typedef union packed {
        rFields_t r;
        iFields_t i;
    } instr_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp_t;

    typedef struct packed {
        logic                   regWrite;
        logic                   memRead;
        logic                   memWrite;
        logic                   useImm;
        logic                   signExtend;
        aluOp_t                 aluOp;
        logic [`REG_ADDR_W-1:0] dest;
    } ctrl_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        ctrl_t            ctrl;
        logic [`XLEN-1:0] opA;
        logic [`XLEN-1:0] opB;
        logic [`XLEN-1:0] imm32;
    } decodedOp_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        ctrl_t            ctrl;
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] storeData;
    } execResult_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`XLEN-1:0]       value;
        logic                   isLoad;
    } fwdSource_t;

    typedef struct packed {
        logic             read;
        logic             write;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } dataReq_t;

    typedef struct packed {
        logic                   wen;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] num;
        logic [`XLEN-1:0]       data;
    } wbTrace_t;

endpackage

// File: cpuTb.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuTb import cpuPkg::*; ();
    localparam int PROG_LEN   = 29;
    localparam int EXP_LEN    = 20;
    // Base pipeline budget plus two wait cycles on each bus per instruction
    localparam int MAX_CYCLES = 10 * PROG_LEN + 4 * PROG_LEN + 3;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] instAddr;
    logic             instRead;
    logic [`XLEN-1:0] instData;
    logic             instValid;
    dataReq_t         dataReq;
    logic [`XLEN-1:0] dataRdata;
    logic             dataValid;
    wbTrace_t         trace;

    logic [`XLEN-1:0]       rom [0:255];
    logic [`XLEN-1:0]       ram [0:63];
    logic [`XLEN-1:0]       progWords [0:PROG_LEN-1];
    logic [`XLEN-1:0]       expPc [0:EXP_LEN-1];
    logic [`REG_ADDR_W-1:0] expNum [0:EXP_LEN-1];
    logic [`XLEN-1:0]       expData [0:EXP_LEN-1];
    int progCount;
    int expCount;
    int expIdx;
    int cycleCount;
    int instWait;
    int dataWait;
    bit dataArmed;
    bit wasReset;
    bit fetchWaiting;
    bit reqWaiting;
    logic [`XLEN-1:0] lastInstAddr;
    dataReq_t         lastReq;

    cpuCore DUT (
        .clk, .reset, .instAddr, .instRead, .instData, .instValid,
        .dataReq, .dataRdata, .dataValid, .trace
    );

    // Instruction data follows the address
    assign instData = rom[instAddr[9:2]];

    function automatic logic [31:0] rWord(input int rs, input int rt, input int rd,
                                          input logic [5:0] fn);
        return {`OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic putInstr(input logic [31:0] word);
        progWords[progCount] = word;
        progCount++;
    endtask

    task automatic expectWrite(input logic [31:0] pc, input int num, input logic [31:0] data);
        expPc[expCount]   = pc;
        expNum[expCount]  = 5'(num);
        expData[expCount] = data;
        expCount++;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset     = 1'b1;
        instValid = 1'b0;
        dataValid = 1'b0;
        dataRdata = '0;
        progCount = 0;
        expCount  = 0;
        expIdx    = 0;
        cycleCount = 0;
        instWait  = 0;
        dataWait  = 0;
        dataArmed = 1'b0;
        wasReset  = 1'b0;
        fetchWaiting = 1'b0;
        reqWaiting   = 1'b0;
        void'($urandom(32'h2ad1));

        putInstr(iWord(`OP_LUI, 0, 1, 16'h1234));
        expectWrite(32'h00, 1, 32'h1234_0000);
        putInstr(iWord(`OP_ORI, 1, 1, 16'h5678));
        expectWrite(32'h04, 1, 32'h1234_5678);
        putInstr(iWord(`OP_ADDIU, 0, 2, 16'hfffd));
        expectWrite(32'h08, 2, 32'hffff_fffd);
        putInstr(rWord(1, 2, 3, `FN_ADDU));
        expectWrite(32'h0c, 3, 32'h1234_5675);
        putInstr(rWord(3, 1, 4, `FN_SUBU));
        expectWrite(32'h10, 4, 32'hffff_fffd);
        putInstr(rWord(3, 1, 5, `FN_AND));
        expectWrite(32'h14, 5, 32'h1234_5670);
        putInstr(rWord(2, 5, 6, `FN_OR));
        expectWrite(32'h18, 6, 32'hffff_fffd);
        putInstr(rWord(2, 1, 7, `FN_SLT));
        expectWrite(32'h1c, 7, 32'h0000_0001);
        // Write to $0 leaves no trace
        putInstr(rWord(1, 1, 0, `FN_ADDU));
        putInstr(iWord(`OP_ADDIU, 0, 8, 16'h0040));
        expectWrite(32'h24, 8, 32'h0000_0040);
        putInstr(iWord(`OP_SW, 8, 1, 16'h0004));
        putInstr(iWord(`OP_LW, 8, 9, 16'h0004));
        expectWrite(32'h2c, 9, 32'h1234_5678);
        putInstr(rWord(9, 7, 10, `FN_ADDU));
        expectWrite(32'h30, 10, 32'h1234_5679);
        putInstr(iWord(`OP_BEQ, 7, 7, 16'h0003));
        putInstr(iWord(`OP_ORI, 0, 11, 16'h0011));
        expectWrite(32'h38, 11, 32'h0000_0011);
        putInstr(iWord(`OP_ORI, 0, 12, 16'h0bad));
        putInstr(iWord(`OP_ORI, 0, 12, 16'h0bad));
        putInstr(iWord(`OP_BNE, 7, 7, 16'h0001));
        putInstr(iWord(`OP_ORI, 0, 13, 16'h0022));
        expectWrite(32'h48, 13, 32'h0000_0022);
        putInstr(iWord(`OP_ORI, 0, 14, 16'h0033));
        expectWrite(32'h4c, 14, 32'h0000_0033);
        putInstr(iWord(`OP_BNE, 14, 13, 16'h0002));
        putInstr(iWord(`OP_ADDIU, 14, 15, 16'h0001));
        expectWrite(32'h54, 15, 32'h0000_0034);
        putInstr(iWord(`OP_ORI, 0, 12, 16'h0bad));
        putInstr(iWord(`OP_BEQ, 14, 13, 16'h0001));
        putInstr(rWord(13, 14, 16, `FN_SLT));
        expectWrite(32'h60, 16, 32'h0000_0001);
        putInstr(iWord(`OP_LW, 0, 17, 16'h0000));
        expectWrite(32'h64, 17, 32'hc0de_0000);
        putInstr(iWord(`OP_LW, 0, 18, 16'h0044));
        expectWrite(32'h68, 18, 32'h1234_5678);
        putInstr(rWord(18, 17, 19, `FN_SUBU));
        expectWrite(32'h6c, 19, 32'h5156_5678);
        putInstr(rWord(19, 19, 20, `FN_ADDU));
        expectWrite(32'h70, 20, 32'ha2ac_acf0);

        // Past the program every word is an undecoded opcode
        for (int i = 0; i < 256; i++) begin
            rom[i] = (i < PROG_LEN) ? progWords[i] : {6'h3f, 26'(i)};
        end
        for (int i = 0; i < 64; i++) begin
            ram[i] = 32'hc0de_0000 + 32'(i * 4);
        end

        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

    // Instruction bus with zero to two wait cycles per fetch
    always @(posedge clk) begin
        if (reset) begin
            instValid <= 1'b0;
            instWait = 0;
        end else if (instValid && instRead) begin
            instWait = $urandom % 3;
            instValid <= (instWait == 0);
        end else if (!instValid) begin
            if (instWait <= 1) begin
                instValid <= 1'b1;
            end else begin
                instWait--;
            end
        end
    end

    // Data bus answering a request while it is held
    always @(posedge clk) begin
        if (reset) begin
            dataValid <= 1'b0;
            dataArmed = 1'b0;
        end else if (dataValid) begin
            dataValid <= 1'b0;
            dataArmed = 1'b0;
        end else if (dataReq.read || dataReq.write) begin
            if (!dataArmed) begin
                dataArmed = 1'b1;
                dataWait  = $urandom % 3;
            end
            if (dataWait == 0) begin
                dataValid <= 1'b1;
                if (dataReq.write) begin
                    ram[dataReq.addr[7:2]] = dataReq.wdata;
                end else begin
                    dataRdata <= ram[dataReq.addr[7:2]];
                end
            end else begin
                dataWait--;
            end
        end
    end

    // Trace checker walks the expected table
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > MAX_CYCLES) begin
            $display("Timeout: trace did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $fatal(1);
        end else if (cycleCount > 1) begin
            if (reset || expIdx == 0) begin
                checkValue("dataReq.read", 32'(dataReq.read), 32'h0);
                checkValue("dataReq.write", 32'(dataReq.write), 32'h0);
            end
            // First fetch right after reset
            if (!reset && wasReset) begin
                checkValue("instRead", 32'(instRead), 32'h1);
                checkValue("instAddr", instAddr, 32'h0000_0000);
            end
            // Both buses hold a request until it is answered
            if (!reset && fetchWaiting && instRead) begin
                checkValue("instAddr", instAddr, lastInstAddr);
            end
            if (!reset && reqWaiting) begin
                checkValue("dataReq.read", 32'(dataReq.read), 32'(lastReq.read));
                checkValue("dataReq.write", 32'(dataReq.write), 32'(lastReq.write));
                checkValue("dataReq.addr", dataReq.addr, lastReq.addr);
                checkValue("dataReq.wdata", dataReq.wdata, lastReq.wdata);
            end
            wasReset     = reset;
            fetchWaiting = !reset && instRead && !instValid;
            lastInstAddr = instAddr;
            reqWaiting   = !reset && (dataReq.read || dataReq.write) && !dataValid;
            lastReq      = dataReq;
            if (reset) begin
                checkValue("trace.wen", 32'(trace.wen), 32'h0);
            end else if (trace.wen) begin
                checkValue("trace.pc", trace.pc, expPc[expIdx]);
                checkValue("trace.num", 32'(trace.num), 32'(expNum[expIdx]));
                checkValue("trace.data", trace.data, expData[expIdx]);
                expIdx++;
                if (expIdx == EXP_LEN) begin
                    $display("TB PASSED");
                    $finish;
                end
            end
        end
    end

endmodule

// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define XLEN       32
`define REG_ADDR_W 5
`define RESET_PC   32'h0000_0000

`define OP_RTYPE 6'h00
`define OP_ADDIU 6'h09
`define OP_ORI   6'h0d
`define OP_LUI   6'h0f
`define OP_LW    6'h23
`define OP_SW    6'h2b
`define OP_BEQ   6'h04
`define OP_BNE   6'h05

`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2a

`endif

// File: decodeUnit.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module decodeUnit import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetchAccept,
    input  instr_t                 instData,
    input  logic [`XLEN-1:0]       instAddr,
    input  logic                   memBusy,
    input  fwdSource_t             execFwd,
    input  fwdSource_t             memFwd,
    input  fwdSource_t             wbFwd,
    output logic [`REG_ADDR_W-1:0] readAddr1,
    output logic [`REG_ADDR_W-1:0] readAddr2,
    input  logic [`XLEN-1:0]       readData1,
    input  logic [`XLEN-1:0]       readData2,
    output logic                   decodeHold,
    output logic                   branchTaken,
    output logic [`XLEN-1:0]       branchTarget,
    output decodedOp_t             decodedOut
);
    logic             decValid;
    instr_t           instr;
    logic [`XLEN-1:0] decPc;
    ctrl_t            ctrl;
    logic             useRs;
    logic             useRt;
    logic             isBeq;
    logic             isBne;
    logic             loadUse;
    logic [`XLEN-1:0] imm32;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;

    function automatic logic hits(input fwdSource_t tap, input logic [`REG_ADDR_W-1:0] src);
        return tap.valid && tap.dest == src && src != '0;
    endfunction

    function automatic logic loadHit(input fwdSource_t tap, input logic [`REG_ADDR_W-1:0] src);
        return hits(tap, src) && tap.isLoad;
    endfunction

    // Nearest stage wins
    function automatic logic [`XLEN-1:0] pickOperand(
        input logic [`REG_ADDR_W-1:0] src,
        input logic [`XLEN-1:0]       rfValue,
        input fwdSource_t             e,
        input fwdSource_t             m,
        input fwdSource_t             w
    );
        logic [`XLEN-1:0] value;
        if (hits(e, src)) begin
            value = e.value;
        end else if (hits(m, src)) begin
            value = m.value;
        end else if (hits(w, src)) begin
            value = w.value;
        end else begin
            value = rfValue;
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            decValid <= 1'b0;
        end else if (!decodeHold && !memBusy) begin
            decValid <= fetchAccept;
        end
    end

    always_ff @(posedge clk) begin
        if (!decodeHold && !memBusy) begin
            instr <= instData;
            decPc <= instAddr;
        end
    end

    // Unknown words fall through as no-ops
    always_comb begin
        ctrl  = '0;
        useRs = 1'b0;
        useRt = 1'b0;
        isBeq = 1'b0;
        isBne = 1'b0;
        case (instr.i.opcode)
            `OP_RTYPE: begin
                useRs         = 1'b1;
                useRt         = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.dest     = instr.r.rd;
                case (instr.r.funct)
                    `FN_ADDU: ctrl.aluOp = aluAdd;
                    `FN_SUBU: ctrl.aluOp = aluSub;
                    `FN_AND:  ctrl.aluOp = aluAnd;
                    `FN_OR:   ctrl.aluOp = aluOr;
                    `FN_SLT:  ctrl.aluOp = aluSlt;
                    default: begin
                        useRs         = 1'b0;
                        useRt         = 1'b0;
                        ctrl.regWrite = 1'b0;
                    end
                endcase
            end
            `OP_ADDIU, `OP_LW: begin
                useRs           = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.memRead    = (instr.i.opcode == `OP_LW);
                ctrl.useImm     = 1'b1;
                ctrl.signExtend = 1'b1;
                ctrl.dest       = instr.i.rt;
            end
            `OP_ORI, `OP_LUI: begin
                useRs         = (instr.i.opcode == `OP_ORI);
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                ctrl.aluOp    = (instr.i.opcode == `OP_ORI) ? aluOr : aluLui;
                ctrl.dest     = instr.i.rt;
            end
            `OP_SW: begin
                useRs           = 1'b1;
                useRt           = 1'b1;
                ctrl.memWrite   = 1'b1;
                ctrl.useImm     = 1'b1;
                ctrl.signExtend = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                useRs           = 1'b1;
                useRt           = 1'b1;
                isBeq           = (instr.i.opcode == `OP_BEQ);
                isBne           = (instr.i.opcode == `OP_BNE);
                ctrl.signExtend = 1'b1;
            end
            default: ;
        endcase
    end

    assign imm32 = ctrl.signExtend ? {{16{instr.i.imm16[15]}}, instr.i.imm16}
                                   : {16'h0000, instr.i.imm16};

    assign readAddr1 = instr.r.rs;
    assign readAddr2 = instr.r.rt;
    assign opA = pickOperand(instr.r.rs, readData1, execFwd, memFwd, wbFwd);
    assign opB = pickOperand(instr.r.rt, readData2, execFwd, memFwd, wbFwd);

    // Load result not back yet
    assign loadUse = (useRs && (loadHit(execFwd, instr.r.rs) || loadHit(memFwd, instr.r.rs)))
                  || (useRt && (loadHit(execFwd, instr.r.rt) || loadHit(memFwd, instr.r.rt)));
    assign decodeHold = decValid && loadUse;

    assign branchTarget = decPc + `XLEN'd4 + {imm32[`XLEN-3:0], 2'b00};
    assign branchTaken  = decValid && !decodeHold
                       && ((isBeq && opA == opB) || (isBne && opA != opB));

    always_comb begin
        decodedOut.valid = decValid && !decodeHold;
        decodedOut.pc    = decPc;
        decodedOut.ctrl  = ctrl;
        decodedOut.opA   = opA;
        decodedOut.opB   = opB;
        decodedOut.imm32 = imm32;
    end

endmodule

// File: executeUnit.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module executeUnit import cpuPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        memBusy,
    input  decodedOp_t  decodedIn,
    output execResult_t execOut,
    output fwdSource_t  execFwd
);
    decodedOp_t       execReg;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            execReg.valid <= 1'b0;
        end else if (!memBusy) begin
            execReg <= decodedIn;
        end
    end

    assign aluB = execReg.ctrl.useImm ? execReg.imm32 : execReg.opB;

    always_comb begin
        case (execReg.ctrl.aluOp)
            aluSub:  aluResult = execReg.opA - aluB;
            aluAnd:  aluResult = execReg.opA & aluB;
            aluOr:   aluResult = execReg.opA | aluB;
            aluSlt:  aluResult = {{(`XLEN-1){1'b0}}, $signed(execReg.opA) < $signed(aluB)};
            aluLui:  aluResult = {aluB[15:0], 16'h0000};
            // Also the load/store address
            default: aluResult = execReg.opA + aluB;
        endcase
    end

    always_comb begin
        execOut.valid     = execReg.valid;
        execOut.pc        = execReg.pc;
        execOut.ctrl      = execReg.ctrl;
        execOut.result    = aluResult;
        execOut.storeData = execReg.opB;
    end

    always_comb begin
        execFwd.valid  = execReg.valid && execReg.ctrl.regWrite;
        execFwd.dest   = execReg.ctrl.dest;
        execFwd.value  = aluResult;
        execFwd.isLoad = execReg.ctrl.memRead;
    end

endmodule

// File: memoryAccess.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module memoryAccess import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  execResult_t            execIn,
    input  logic [`XLEN-1:0]       dataRdata,
    input  logic                   dataValid,
    output dataReq_t               dataReq,
    output logic                   memBusy,
    output fwdSource_t             memFwd,
    output fwdSource_t             wbFwd,
    output logic                   rfWriteEn,
    output logic [`REG_ADDR_W-1:0] rfWriteAddr,
    output logic [`XLEN-1:0]       rfWriteData,
    output wbTrace_t               trace
);
    execResult_t            memReg;
    logic                   memAccess;
    logic                   wbWrite;
    logic [`XLEN-1:0]       wbPc;
    logic [`REG_ADDR_W-1:0] wbDest;
    logic [`XLEN-1:0]       wbData;

    always_ff @(posedge clk) begin
        if (reset) begin
            memReg.valid <= 1'b0;
        end else if (!memBusy) begin
            memReg <= execIn;
        end
    end

    assign memAccess = memReg.valid && (memReg.ctrl.memRead || memReg.ctrl.memWrite);
    // Request held until the bus answers
    assign memBusy   = memAccess && !dataValid;

    always_comb begin
        dataReq.read  = memReg.valid && memReg.ctrl.memRead;
        dataReq.write = memReg.valid && memReg.ctrl.memWrite;
        dataReq.addr  = memReg.result;
        dataReq.wdata = memReg.storeData;
    end

    always_comb begin
        memFwd.valid  = memReg.valid && memReg.ctrl.regWrite;
        memFwd.dest   = memReg.ctrl.dest;
        memFwd.value  = memReg.result;
        memFwd.isLoad = memReg.ctrl.memRead;
    end

    // Writeback takes a bubble while memory waits
    always_ff @(posedge clk) begin
        if (reset) begin
            wbWrite <= 1'b0;
        end else begin
            wbWrite <= memReg.valid && !memBusy && memReg.ctrl.regWrite
                    && memReg.ctrl.dest != '0;
        end
    end

    always_ff @(posedge clk) begin
        wbPc   <= memReg.pc;
        wbDest <= memReg.ctrl.dest;
        wbData <= memReg.ctrl.memRead ? dataRdata : memReg.result;
    end

    assign rfWriteEn   = wbWrite;
    assign rfWriteAddr = wbDest;
    assign rfWriteData = wbData;

    always_comb begin
        wbFwd.valid  = wbWrite;
        wbFwd.dest   = wbDest;
        wbFwd.value  = wbData;
        wbFwd.isLoad = 1'b0;
    end

    always_comb begin
        trace.wen  = wbWrite;
        trace.pc   = wbPc;
        trace.num  = wbDest;
        trace.data = wbData;
    end

endmodule

// File: programCounter.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module programCounter (
    input  logic             clk,
    input  logic             reset,
    input  logic             instValid,
    input  logic             branchTaken,
    input  logic             decodeHold,
    input  logic             memBusy,
    input  logic [`XLEN-1:0] branchTarget,
    output logic [`XLEN-1:0] instAddr,
    output logic             instRead,
    output logic             fetchAccept
);
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] pendingTarget;
    logic             pendingValid;

    // No fetch while the front of the pipeline is frozen
    assign instRead    = !(decodeHold || memBusy);
    assign fetchAccept = instRead && instValid;
    assign instAddr    = pc;

    // The word fetched while a branch resolves is its delay slot
    always_comb begin
        if (branchTaken) begin
            nextPc = branchTarget;
        end else if (pendingValid) begin
            nextPc = pendingTarget;
        end else begin
            nextPc = pc + `XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc           <= `RESET_PC;
            pendingValid <= 1'b0;
        end else if (fetchAccept) begin
            pc           <= nextPc;
            pendingValid <= 1'b0;
        end else if (branchTaken) begin
            // Delay slot not fetched yet so the redirect waits
            pendingValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (branchTaken) begin
            pendingTarget <= branchTarget;
        end
    end

endmodule

// File: project.f
+incdir+.
cpuPkg.sv
programCounter.sv
registerFile.sv
decodeUnit.sv
executeUnit.sv
memoryAccess.sv
cpuCore.sv
cpuTb.sv

// File: registerFile.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module registerFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] readAddr1,
    input  logic [`REG_ADDR_W-1:0] readAddr2,
    output logic [`XLEN-1:0]       readData1,
    output logic [`XLEN-1:0]       readData2,
    input  logic                   writeEn,
    input  logic [`REG_ADDR_W-1:0] writeAddr,
    input  logic [`XLEN-1:0]       writeData
);
    logic [`XLEN-1:0] regs [1:31];

    // Register 0 is hardwired to zero
    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

    always_ff @(posedge clk) begin
        if (writeEn && !reset && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule
